// File: pru_pkg.sv
package pru_pkg;

    // Coordinate and colour widths
    localparam int X_W   = 10;              // Column coordinate
    localparam int Y_W   = 9;               // Row coordinate
    localparam int PIX_W = 2;               // Colour index per pixel
    localparam int CH_W  = 10;              // One RGB channel

    // Shape select codes
    localparam logic [1:0] SHAPE_RECT   = 2'd0;
    localparam logic [1:0] SHAPE_CIRCLE = 2'd1;
    localparam logic [1:0] SHAPE_SPRITE = 2'd2;
    localparam logic [1:0] SHAPE_CLEAR  = 2'd3;

    // Address of palette entry 0 with the others every 4 bytes
    localparam logic [31:0] PAL_BASE = 32'h0000_4000;

    // Sprite edge length in pixels
    localparam int SPR_SIZE = 32;

endpackage

// File: pix_wr_if.sv
`timescale 1ns/10ps

interface pix_wr_if;

    logic                      we;      // Write this cycle
    logic [pru_pkg::X_W-1:0]   x;
    logic [pru_pkg::Y_W-1:0]   y;
    logic [pru_pkg::PIX_W-1:0] idx;     // Colour index to store

    // Rasterizer side
    modport src (output we, x, y, idx);

    // Frame buffer side
    modport dst (input we, x, y, idx);

endinterface

// File: sprite_rom.sv
`timescale 1ns/10ps

module sprite_rom (
    input  logic       clk,
    input  logic [9:0] i_addr,          // Sprite row in the upper half
    output logic       o_bit
);

    localparam int SPR_AW = $clog2(pru_pkg::SPR_SIZE);

    // One word per sprite line with column 0 leftmost
    logic [0:pru_pkg::SPR_SIZE-1] rows [pru_pkg::SPR_SIZE];

    initial begin
        $readmemb("sprite.mem", rows);
    end

    always_ff @(posedge clk) begin
        o_bit <= rows[i_addr[2*SPR_AW-1:SPR_AW]][i_addr[SPR_AW-1:0]];
    end

endmodule

// File: frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer #(
    parameter int H_RES = 640,
    parameter int V_RES = 480,
    localparam int AW   = $clog2(H_RES * V_RES)
) (
    input  logic                      clk,
    pix_wr_if.dst                     wr,
    input  logic                      i_rd_en,
    input  logic [AW-1:0]             i_rd_addr,
    output logic [pru_pkg::PIX_W-1:0] o_rd_idx
);

    localparam int DEPTH = H_RES * V_RES;

    logic [pru_pkg::PIX_W-1:0] mem [DEPTH];
    logic [AW-1:0]             wr_addr;

    // Row major like the scan-out order
    assign wr_addr = AW'(wr.y * H_RES + wr.x);

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_addr] <= wr.idx;
        end
        if (i_rd_en) begin
            o_rd_idx <= mem[i_rd_addr];                     // Old data on a collision
        end
    end

endmodule

// File: palette_regs.sv
`timescale 1ns/10ps

module palette_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_reg_wr,
    input  logic [31:0]               i_reg_addr,
    input  logic [31:0]               i_reg_data,
    input  logic [pru_pkg::PIX_W-1:0] i_idx,
    input  logic                      i_idx_valid,
    output logic                      o_pix_valid,
    output logic [pru_pkg::CH_W-1:0]  o_red,
    output logic [pru_pkg::CH_W-1:0]  o_green,
    output logic [pru_pkg::CH_W-1:0]  o_blue
);

    localparam int N_PAL = 1 << pru_pkg::PIX_W;
    localparam int CH    = pru_pkg::CH_W;

    // Blue high, green middle, red low
    logic [3*CH-1:0] pal [N_PAL];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < N_PAL; k++) begin
                pal[k] <= '0;
            end
        end else if (i_reg_wr) begin
            for (int k = 0; k < N_PAL; k++) begin
                // Exact address match only
                if (i_reg_addr == pru_pkg::PAL_BASE + 32'(4 * k)) begin
                    pal[k] <= i_reg_data[3*CH-1:0];
                end
            end
        end
    end

    // One cycle colour lookup
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pix_valid <= 1'b0;
            o_red       <= '0;
            o_green     <= '0;
            o_blue      <= '0;
        end else begin
            o_pix_valid <= i_idx_valid;
            if (i_idx_valid) begin
                o_red   <= pal[i_idx][CH-1:0];
                o_green <= pal[i_idx][2*CH-1:CH];
                o_blue  <= pal[i_idx][3*CH-1:2*CH];
            end
        end
    end

endmodule

// File: scanout.sv
`timescale 1ns/10ps

module scanout #(
    parameter int H_RES = 640,
    parameter int V_RES = 480,
    localparam int AW   = $clog2(H_RES * V_RES)
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_pix_rd,     // One pixel per pulse
    output logic          o_rd_en,
    output logic [AW-1:0] o_rd_addr,
    output logic          o_idx_valid
);

    localparam int DEPTH = H_RES * V_RES;

    logic [AW-1:0] pix_cnt;             // Next pixel in row major order
    logic          frame_end;

    assign frame_end = (pix_cnt == AW'(DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt     <= '0;
            o_idx_valid <= 1'b0;
        end else begin
            o_idx_valid <= i_pix_rd;                        // Index comes back next cycle
            if (i_pix_rd) begin
                pix_cnt <= frame_end ? '0 : pix_cnt + 1'b1;
            end
        end
    end

    // Read goes to the frame buffer in the pulse cycle
    assign o_rd_en   = i_pix_rd;
    assign o_rd_addr = pix_cnt;

endmodule

// File: shape_raster.sv
`timescale 1ns/10ps

module shape_raster #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  logic [1:0]                i_shape,
    input  logic [pru_pkg::PIX_W-1:0] i_idx,
    input  logic [pru_pkg::X_W-1:0]   i_col,
    input  logic [pru_pkg::Y_W-1:0]   i_row,
    input  logic [pru_pkg::X_W-1:0]   i_width,
    input  logic [pru_pkg::Y_W-1:0]   i_height_radius,
    output logic [9:0]                o_spr_addr,
    input  logic                      i_spr_bit,
    output logic                      o_busy,
    output logic                      o_done,
    pix_wr_if.src                     wr
);

    localparam int CW     = pru_pkg::X_W + 3;              // Signed column width
    localparam int RW     = pru_pkg::Y_W + 3;              // Signed row width
    localparam int DW     = 2 * CW + 1;                    // Squared distance
    localparam int SPR_AW = $clog2(pru_pkg::SPR_SIZE);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_DRAW  = 2'd1;
    localparam logic [1:0] ST_FLUSH = 2'd2;                // Last write leaves the pipe
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0] state;

    logic signed [CW-1:0] col_s, wid_s, rad_x;
    logic signed [RW-1:0] row_s, hgt_s, rad_y;
    logic signed [CW-1:0] nx_lo, nx_hi;
    logic signed [RW-1:0] ny_lo, ny_hi;

    // Drawing latched at start
    logic [1:0]                shape_q;
    logic [pru_pkg::PIX_W-1:0] idx_q;
    logic [pru_pkg::Y_W-1:0]   rad_q;
    logic signed [CW-1:0]      cx_q, x_lo, x_hi, x_cur, sx;
    logic signed [RW-1:0]      cy_q, y_lo, y_hi, y_cur, sy;

    logic signed [CW-1:0] dx;
    logic signed [RW-1:0] dy;
    logic signed [DW-1:0] dist_sq, rad_sq;
    logic                 on_screen, in_circle, hit, last_col, last_pos;

    // Position stage waiting for the sprite ROM bit
    logic                      p_valid, p_hit, p_spr;
    logic [pru_pkg::X_W-1:0]   p_x;
    logic [pru_pkg::Y_W-1:0]   p_y;

    assign col_s = $signed({3'b000, i_col});
    assign wid_s = $signed({3'b000, i_width});
    assign rad_x = $signed({{(CW - pru_pkg::Y_W){1'b0}}, i_height_radius});
    assign row_s = $signed({3'b000, i_row});
    assign hgt_s = $signed({3'b000, i_height_radius});
    assign rad_y = hgt_s;

    // Bounding box of the requested shape
    always_comb begin
        nx_lo = col_s;
        ny_lo = row_s;
        nx_hi = col_s + wid_s - CW'(1);
        ny_hi = row_s + hgt_s - RW'(1);
        case (i_shape)
            pru_pkg::SHAPE_CIRCLE: begin
                nx_lo = col_s - rad_x;                      // May go negative
                nx_hi = col_s + rad_x;
                ny_lo = row_s - rad_y;
                ny_hi = row_s + rad_y;
            end
            pru_pkg::SHAPE_SPRITE: begin
                nx_hi = col_s + CW'(pru_pkg::SPR_SIZE - 1);
                ny_hi = row_s + RW'(pru_pkg::SPR_SIZE - 1);
            end
            pru_pkg::SHAPE_CLEAR: begin
                nx_lo = '0;
                ny_lo = '0;
                nx_hi = CW'(H_RES - 1);
                ny_hi = RW'(V_RES - 1);
            end
            default: begin
            end
        endcase
    end

    // Per position decision
    assign dx        = x_cur - cx_q;
    assign dy        = y_cur - cy_q;
    assign dist_sq   = dx * dx + dy * dy;
    assign rad_sq    = $signed({1'b0, rad_q}) * $signed({1'b0, rad_q});
    assign in_circle = (dist_sq <= rad_sq);
    assign on_screen = (x_cur >= 0) && (x_cur < CW'(H_RES)) &&
                       (y_cur >= 0) && (y_cur < RW'(V_RES));
    assign hit       = on_screen && ((shape_q != pru_pkg::SHAPE_CIRCLE) || in_circle);
    assign last_col  = (x_cur == x_hi);
    assign last_pos  = last_col && (y_cur == y_hi);

    // Row major bit index inside the sprite
    assign sx         = x_cur - x_lo;
    assign sy         = y_cur - y_lo;
    assign o_spr_addr = {sy[SPR_AW-1:0], sx[SPR_AW-1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            p_valid <= 1'b0;
        end else begin
            p_valid <= (state == ST_DRAW);
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        // Empty box skips straight to the end
                        state <= (nx_hi < nx_lo || ny_hi < ny_lo) ? ST_FLUSH : ST_DRAW;
                    end
                end
                ST_DRAW: begin
                    if (last_pos) state <= ST_FLUSH;
                end
                ST_FLUSH: state <= ST_DONE;
                default: begin
                    if (!i_start) state <= ST_IDLE;       // Hold done until start drops
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_start) begin
            shape_q <= i_shape;
            idx_q   <= (i_shape == pru_pkg::SHAPE_CLEAR) ? '0 : i_idx;
            rad_q   <= i_height_radius;
            cx_q    <= col_s;
            cy_q    <= row_s;
            x_lo    <= nx_lo;
            x_hi    <= nx_hi;
            y_lo    <= ny_lo;
            y_hi    <= ny_hi;
            x_cur   <= nx_lo;
            y_cur   <= ny_lo;
        end else if (state == ST_DRAW) begin
            if (last_col) begin                             // Column fastest
                x_cur <= x_lo;
                y_cur <= y_cur + RW'(1);
            end else begin
                x_cur <= x_cur + CW'(1);
            end
        end
        p_hit <= hit;
        p_spr <= (shape_q == pru_pkg::SHAPE_SPRITE);
        p_x   <= x_cur[pru_pkg::X_W-1:0];
        p_y   <= y_cur[pru_pkg::Y_W-1:0];
    end

    // Sprite bit arrives together with the staged position
    assign wr.we  = p_valid && p_hit && (!p_spr || i_spr_bit);
    assign wr.x   = p_x;
    assign wr.y   = p_y;
    assign wr.idx = idx_q;

    assign o_busy = (state == ST_DRAW) || (state == ST_FLUSH);
    assign o_done = (state == ST_DONE);

endmodule

// File: pru_top.sv
`timescale 1ns/10ps

module pru_top #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  logic [1:0]                i_shape,
    input  logic [pru_pkg::PIX_W-1:0] i_idx,
    input  logic [pru_pkg::X_W-1:0]   i_col,
    input  logic [pru_pkg::Y_W-1:0]   i_row,
    input  logic [pru_pkg::X_W-1:0]   i_width,
    input  logic [pru_pkg::Y_W-1:0]   i_height_radius,
    input  logic                      i_reg_wr,
    input  logic [31:0]               i_reg_addr,
    input  logic [31:0]               i_reg_data,
    input  logic                      i_pix_rd,
    output logic                      o_busy,
    output logic                      o_done,
    output logic                      o_pix_valid,
    output logic [pru_pkg::CH_W-1:0]  o_red,
    output logic [pru_pkg::CH_W-1:0]  o_green,
    output logic [pru_pkg::CH_W-1:0]  o_blue
);

    localparam int FB_AW = $clog2(H_RES * V_RES);

    logic [9:0]                spr_addr;
    logic                      spr_bit;
    logic                      rd_en;
    logic [FB_AW-1:0]          rd_addr;
    logic [pru_pkg::PIX_W-1:0] rd_idx;
    logic                      idx_valid;

    pix_wr_if wr_bus ();                // Rasterizer to frame buffer

    shape_raster #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) u_raster (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_start         (i_start),
        .i_shape         (i_shape),
        .i_idx           (i_idx),
        .i_col           (i_col),
        .i_row           (i_row),
        .i_width         (i_width),
        .i_height_radius (i_height_radius),
        .o_spr_addr      (spr_addr),
        .i_spr_bit       (spr_bit),
        .o_busy          (o_busy),
        .o_done          (o_done),
        .wr              (wr_bus.src)
    );

    sprite_rom u_sprite (
        .clk    (clk),
        .i_addr (spr_addr),
        .o_bit  (spr_bit)
    );

    frame_buffer #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) u_frame (
        .clk       (clk),
        .wr        (wr_bus.dst),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_idx  (rd_idx)
    );

    scanout #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) u_scan (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_pix_rd    (i_pix_rd),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .o_idx_valid (idx_valid)
    );

    palette_regs u_palette (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_reg_wr    (i_reg_wr),
        .i_reg_addr  (i_reg_addr),
        .i_reg_data  (i_reg_data),
        .i_idx       (rd_idx),
        .i_idx_valid (idx_valid),
        .o_pix_valid (o_pix_valid),
        .o_red       (o_red),
        .o_green     (o_green),
        .o_blue      (o_blue)
    );

endmodule

// File: tb_pru.sv
`timescale 1ns/10ps

module tb_pru;

    localparam int H_RES = 64;
    localparam int V_RES = 48;
    localparam int NPIX  = H_RES * V_RES;
    localparam int CH    = pru_pkg::CH_W;

    logic                      clk;
    logic                      rst_n;
    logic                      i_start;
    logic [1:0]                i_shape;
    logic [pru_pkg::PIX_W-1:0] i_idx;
    logic [pru_pkg::X_W-1:0]   i_col;
    logic [pru_pkg::Y_W-1:0]   i_row;
    logic [pru_pkg::X_W-1:0]   i_width;
    logic [pru_pkg::Y_W-1:0]   i_height_radius;
    logic                      i_reg_wr;
    logic [31:0]               i_reg_addr;
    logic [31:0]               i_reg_data;
    logic                      i_pix_rd;
    logic                      o_busy, o_done, o_pix_valid;
    logic [CH-1:0]             o_red, o_green, o_blue;

    // Reference state
    logic [pru_pkg::PIX_W-1:0]    fm [NPIX];            // Expected frame in row major order
    logic [3*CH-1:0]              pal_m [4];
    logic [0:pru_pkg::SPR_SIZE-1] spr [pru_pkg::SPR_SIZE];

    int errors, err_mark, pass_cnt, fail_cnt, k, sel;
    logic [31:0] addr;

    pru_top #(.H_RES(H_RES), .V_RES(V_RES)) dut0 (.*);

    always #10 clk = ~clk;

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_rgb(input string what, input logic [CH-1:0] r, g, b,
                             input logic [CH-1:0] er, eg, eb);
        if (r !== er || g !== eg || b !== eb) begin
            errors++;
            $display("[ERROR] %0t: %s rgb %h/%h/%h, expected %h/%h/%h",
                     $time, what, r, g, b, er, eg, eb);
        end
    endtask

    task automatic put_pix(input int x, input int y, input logic [1:0] idx);
        if (x >= 0 && x < H_RES && y >= 0 && y < V_RES) begin
            fm[y * H_RES + x] = idx;
        end
    endtask

    // Reference rasterizer for every shape code
    task automatic apply_shape(input logic [1:0] shape, input int idx, col, row, w, hr);
        int x;
        int y;
        case (shape)
            pru_pkg::SHAPE_RECT: begin
                for (y = row; y < row + hr; y++)
                    for (x = col; x < col + w; x++) put_pix(x, y, idx);
            end
            pru_pkg::SHAPE_CIRCLE: begin
                for (y = row - hr; y <= row + hr; y++)
                    for (x = col - hr; x <= col + hr; x++)
                        if ((x - col) * (x - col) + (y - row) * (y - row) <= hr * hr)
                            put_pix(x, y, idx);
            end
            pru_pkg::SHAPE_SPRITE: begin
                for (y = 0; y < pru_pkg::SPR_SIZE; y++)
                    for (x = 0; x < pru_pkg::SPR_SIZE; x++)
                        if (spr[y][x]) put_pix(col + x, row + y, idx);
            end
            default: begin
                foreach (fm[i]) fm[i] = '0;
            end
        endcase
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        i_reg_wr   = 1'b1;
        i_reg_addr = a;
        i_reg_data = d;
        @(negedge clk);
        i_reg_wr = 1'b0;
        for (int n = 0; n < 4; n++) begin
            if (a == pru_pkg::PAL_BASE + 32'(4 * n)) pal_m[n] = d[29:0];
        end
    endtask

    // One drawing where glitch toggles start and inputs while busy
    task automatic draw(input logic [1:0] shape, input int idx, col, row, w, hr,
                        input bit glitch);
        int cnt;
        int hold;
        @(negedge clk);
        i_shape         = shape;
        i_idx           = idx;
        i_col           = col;
        i_row           = row;
        i_width         = w;
        i_height_radius = hr;
        i_start         = 1'b1;
        @(negedge clk);
        check_flag("busy after start", o_busy, 1'b1);
        cnt = 0;
        while (!o_done && cnt < 8000) begin
            if (glitch && cnt < 6) begin
                i_start = cnt[0];
                i_col   = $urandom;
                i_shape = $urandom;
            end else begin
                i_start = 1'b1;
            end
            @(negedge clk);
            cnt++;
        end
        if (!o_done) begin
            errors++;
            $display("Timeout: drawing of shape %0d never reported done", shape);
        end
        check_flag("busy at done", o_busy, 1'b0);
        hold = $urandom_range(1, 4);
        repeat (hold) begin
            @(negedge clk);
            check_flag("done while start held", o_done, 1'b1);
            check_flag("busy while start held", o_busy, 1'b0);
        end
        i_start = 1'b0;
        @(negedge clk);
        check_flag("done after start low", o_done, 1'b0);
        apply_shape(shape, idx, col, row, w, hr);
    endtask

    // Full frame through scan-out and palette
    task automatic read_frame();
        int issued;
        int checked;
        int cyc;
        logic [3*CH-1:0] e;
        issued  = 0;
        checked = 0;
        cyc     = 0;
        while (checked < NPIX && cyc < NPIX + 16) begin
            @(negedge clk);
            check_flag("pix_valid", o_pix_valid, cyc >= 2 && cyc < NPIX + 2);
            if (o_pix_valid) begin
                e = pal_m[fm[checked]];
                check_rgb($sformatf("pixel %0d", checked), o_red, o_green, o_blue,
                          e[CH-1:0], e[2*CH-1:CH], e[3*CH-1:2*CH]);
                checked++;
            end
            i_pix_rd = (issued < NPIX);
            if (issued < NPIX) issued++;
            cyc++;
        end
        i_pix_rd = 1'b0;
        if (checked < NPIX) begin
            errors++;
            $display("Timeout: frame read returned %0d of %0d pixels", checked, NPIX);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        void'($urandom(46));
        $readmemb("sprite.mem", spr);
        clk = 0;
        rst_n = 0;
        i_start = 0;
        i_shape = '0;
        i_idx = '0;
        i_col = '0;
        i_row = '0;
        i_width = '0;
        i_height_radius = '0;
        i_reg_wr = 0;
        i_reg_addr = '0;
        i_reg_data = '0;
        i_pix_rd = 0;
        errors = 0;
        err_mark = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        foreach (pal_m[i]) pal_m[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1;

        @(negedge clk);
        check_flag("busy after reset", o_busy, 1'b0);
        check_flag("done after reset", o_done, 1'b0);
        check_flag("pix_valid after reset", o_pix_valid, 1'b0);
        check_rgb("colour after reset", o_red, o_green, o_blue, '0, '0, '0);
        draw(pru_pkg::SHAPE_CLEAR, 0, 0, 0, 0, 0, 1'b0);
        read_frame();
        end_test("reset state");

        for (k = 0; k < 4; k++) write_reg(pru_pkg::PAL_BASE + 32'(4 * k), $urandom);
        for (k = 0; k < 16; k++) begin
            sel = $urandom_range(0, 7);
            case (sel)
                4: addr = pru_pkg::PAL_BASE + 32'd16;
                5: addr = pru_pkg::PAL_BASE + 32'(4 * $urandom_range(0, 3) + 2);
                6: addr = pru_pkg::PAL_BASE - 32'd4;
                7: addr = 32'(4 * $urandom_range(0, 3));
                default: addr = pru_pkg::PAL_BASE + 32'(4 * sel);
            endcase
            write_reg(addr, $urandom);
        end
        draw(pru_pkg::SHAPE_CLEAR, 0, 0, 0, 0, 0, 1'b0);
        read_frame();
        end_test("palette");

        for (k = 0; k < 20; k++)
            draw(pru_pkg::SHAPE_RECT, $urandom_range(0, 3), $urandom_range(0, H_RES - 1),
                 $urandom_range(0, V_RES - 1), $urandom_range(1, 40), $urandom_range(1, 30), 0);
        read_frame();
        end_test("rectangles");

        for (k = 0; k < 12; k++)                            // First one has radius 0
            draw(pru_pkg::SHAPE_CIRCLE, $urandom_range(1, 3), $urandom_range(0, H_RES + 4),
                 $urandom_range(0, V_RES + 4), 0, (k == 0) ? 0 : $urandom_range(0, 20), 0);
        read_frame();
        end_test("circles");

        for (k = 0; k < 6; k++)
            draw(pru_pkg::SHAPE_SPRITE, $urandom_range(0, 3), $urandom_range(0, H_RES - 1),
                 $urandom_range(0, V_RES - 1), 0, 0, 0);
        read_frame();
        draw(pru_pkg::SHAPE_CLEAR, 0, 0, 0, 0, 0, 1'b0);
        read_frame();
        end_test("sprites and clear");

        draw(pru_pkg::SHAPE_RECT, $urandom_range(1, 3), $urandom_range(0, 40),
             $urandom_range(0, 30), $urandom_range(8, 30), $urandom_range(4, 20), 1'b1);
        draw(pru_pkg::SHAPE_SPRITE, $urandom_range(1, 3), $urandom_range(0, 40),
             $urandom_range(0, 30), 0, 0, 1'b1);
        read_frame();
        end_test("start protocol");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sprite.mem
// One sprite row per line, leftmost digit is column 0
11111111111111111111111111111111
11000000000000000000000000000011
10100000000000000000000000000101
10010000000000000000000000001001
10001000000000000000111111110001
10000100000000000000000000100001
10000010000000000000000001000001
10000001000000000000000010000001
10000000100000000000000100000001
10000000010000000000001000000001
10000000001000000000010000000001
10000000000100000000100000000001
10000000000010000001000000000001
10000000000001000010000000000001
10000000000000100100000000000001
10000000000000011000000000000001
10000000000000011000000000000001
10000000000000100100000000000001
10000000000001000010000000000001
10000000000010000001000000000001
10000000000100000000100000000001
10000000001000000000010000000001
10000000010000000000001000000001
10000000100000000000000100000001
10000001000000000000000010000001
10000010000000000000000001000001
10000100000000000000000000100001
10001000000000000000000000010001
10010000000000000000000000001001
10100000000000000000000000000101
11000000000000000000000000000011
11111111111111111111111111111111

// File: project.f
pru_pkg.sv
pix_wr_if.sv
sprite_rom.sv
frame_buffer.sv
palette_regs.sv
scanout.sv
shape_raster.sv
pru_top.sv
tb_pru.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_pru -f project.f \
    && ./obj_dir/Vtb_pru > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }
